// ==== matmul_systolic.f ====
+incdir+logic
logic/matmul_pkg.sv
logic/systolic_pe.sv
logic/systolic_pe_matrix.sv
logic/systolic_data_setup.sv
logic/output_logic.sv
logic/matmul_4x4_systolic.sv
bench/tb_clock_gen.sv
bench/tb_matmul_mem.sv
bench/tb_matmul.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the multiplier testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --timescale 1ns/1ps \
    -f matmul_systolic.f --top-module tb_matmul \
    --Mdir "$BUILD_DIR" -o tb_matmul_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_matmul_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1

// ==== bench/tb_matmul.sv ====
// Testbench for the 4x4 systolic multiplier
// Runs a table of cases against a golden model of the masked, wrapping product

`timescale 1ns/1ps

`include "matmul_params.svh"

module tb_matmul
    import matmul_pkg::*;
();

    localparam int N          = `MAT_MUL_SIZE;
    localparam int NUM_CASES  = 8;
    localparam int LATENCY    = 15;
    localparam int CASE_LIMIT = 40;

    logic    clk;
    logic    arst_n;
    logic    start_mat_mul;
    logic    done_mat_mul;
    logic    log_clear;
    addr_t   address_mat_a;
    addr_t   address_mat_b;
    addr_t   address_mat_c;
    stride_t address_stride_a;
    stride_t address_stride_b;
    stride_t address_stride_c;
    mask_t   validity_mask_a_rows;
    mask_t   validity_mask_a_cols_b_rows;
    mask_t   validity_mask_b_cols;
    vec_t    a_data;
    vec_t    b_data;
    vec_t    c_data_out;
    addr_t   a_addr;
    addr_t   b_addr;
    addr_t   c_addr;
    logic    a_mem_access;
    logic    b_mem_access;
    logic    c_data_available;

    // Case table
    string   tab_name      [NUM_CASES];
    elem_t   tab_a         [NUM_CASES][N][N];
    elem_t   tab_b         [NUM_CASES][N][N];
    addr_t   tab_base_a    [NUM_CASES];
    addr_t   tab_base_b    [NUM_CASES];
    addr_t   tab_base_c    [NUM_CASES];
    stride_t tab_str_a     [NUM_CASES];
    stride_t tab_str_b     [NUM_CASES];
    stride_t tab_str_c     [NUM_CASES];
    mask_t   tab_mask_rows [NUM_CASES];
    mask_t   tab_mask_k    [NUM_CASES];
    mask_t   tab_mask_cols [NUM_CASES];

    int          errors;
    int          fails;
    int unsigned lcg_state = 32'd39555;

    tb_clock_gen u_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    tb_matmul_mem u_mem (
        .clk              (clk),
        .log_clear        (log_clear),
        .a_mem_access     (a_mem_access),
        .b_mem_access     (b_mem_access),
        .a_addr           (a_addr),
        .b_addr           (b_addr),
        .c_data_available (c_data_available),
        .c_addr           (c_addr),
        .c_data_out       (c_data_out),
        .a_data           (a_data),
        .b_data           (b_data)
    );

    matmul_4x4_systolic i_dut (
        .clk                         (clk),
        .arst_n                      (arst_n),
        .start_mat_mul               (start_mat_mul),
        .done_mat_mul                (done_mat_mul),
        .address_mat_a               (address_mat_a),
        .address_mat_b               (address_mat_b),
        .address_mat_c               (address_mat_c),
        .address_stride_a            (address_stride_a),
        .address_stride_b            (address_stride_b),
        .address_stride_c            (address_stride_c),
        .validity_mask_a_rows        (validity_mask_a_rows),
        .validity_mask_a_cols_b_rows (validity_mask_a_cols_b_rows),
        .validity_mask_b_cols        (validity_mask_b_cols),
        .a_data                      (a_data),
        .b_data                      (b_data),
        .a_addr                      (a_addr),
        .b_addr                      (b_addr),
        .c_addr                      (c_addr),
        .a_mem_access                (a_mem_access),
        .b_mem_access                (b_mem_access),
        .c_data_available            (c_data_available),
        .c_data_out                  (c_data_out)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic elem_t lcg_elem();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return elem_t'(lcg_state >> 16);
    endfunction

    function automatic cnt_t controls();
        return cnt_t'({done_mat_mul, c_data_available, a_mem_access, b_mem_access});
    endfunction

    task automatic check_vec(input vec_t got, input vec_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input cnt_t got, input cnt_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Row i of C, with A and B masked on input and C masked on output
    function automatic vec_t golden_row(input int c, input int i);
        vec_t   row;
        longint sum;
        for (int j = 0; j < N; j++) begin
            sum = 0;
            for (int k = 0; k < N; k++) begin
                if (tab_mask_k[c][k]) begin
                    sum += longint'(tab_a[c][i][k]) * longint'(tab_b[c][k][j]);
                end
            end
            row[j] = (tab_mask_rows[c][i] && tab_mask_cols[c][j]) ? elem_t'(sum) : '0;
        end
        return row;
    endfunction

    ////////////////////////////////////////
    // Case table
    ////////////////////////////////////////

    task automatic set_case(input int c, input string name, input addr_t ba, input addr_t bb,
                            input addr_t bc, input stride_t sa, input stride_t sb,
                            input stride_t sc, input mask_t mr, input mask_t mk,
                            input mask_t mc);
        tab_name[c]      = name;
        tab_base_a[c]    = ba;
        tab_base_b[c]    = bb;
        tab_base_c[c]    = bc;
        tab_str_a[c]     = sa;
        tab_str_b[c]     = sb;
        tab_str_c[c]     = sc;
        tab_mask_rows[c] = mr;
        tab_mask_k[c]    = mk;
        tab_mask_cols[c] = mc;
    endtask

    task automatic build_table();
        for (int c = 0; c < NUM_CASES; c++) begin
            for (int i = 0; i < N; i++) begin
                for (int j = 0; j < N; j++) begin
                    case (c)
                        0: begin
                            tab_a[c][i][j] = (i == j) ? 16'sd1 : 16'sd0;
                            tab_b[c][i][j] = elem_t'(i * 4 + j + 1);
                        end
                        1, 4: begin
                            tab_a[c][i][j] = elem_t'(i + j + 1);
                            tab_b[c][i][j] = elem_t'(j - i);
                        end
                        6: begin
                            tab_a[c][i][j] = -16'sd1;
                            tab_b[c][i][j] = elem_t'(i - 2 * j);
                        end
                        7: begin
                            tab_a[c][i][j] = 16'sh7fff;
                            tab_b[c][i][j] = 16'sh7fff;
                        end
                        default: begin
                            tab_a[c][i][j] = lcg_elem();
                            tab_b[c][i][j] = lcg_elem();
                        end
                    endcase
                end
            end
        end
        set_case(0, "identity times known", 0, 0, 0, 1, 1, 1, 4'hf, 4'hf, 4'hf);
        set_case(1, "known product, new bases", 16, 64, 128, 2, 3, 4, 4'hf, 4'hf, 4'hf);
        set_case(2, "random full", 100, 300, 500, 7, 9, 11, 4'hf, 4'hf, 4'hf);
        set_case(3, "random, address wrap", 1000, 900, 1020, 255, 200, 3, 4'hf, 4'hf, 4'hf);
        set_case(4, "partial masks", 20, 40, 60, 5, 5, 5, 4'b0111, 4'b1011, 4'b1101);
        set_case(5, "random 2x2 corner", 8, 8, 8, 1, 1, 1, 4'b0011, 4'b0011, 4'b0011);
        set_case(6, "sparse masks, negatives", 512, 600, 700, 1, 1, 2, 4'b1010, 4'hf, 4'b0101);
        set_case(7, "large values wrap", 3, 7, 11, 13, 17, 19, 4'hf, 4'hf, 4'hf);
    endtask

    ////////////////////////////////////////
    // One run of the multiplier
    ////////////////////////////////////////

    task automatic run_case(input int c);
        int   e0;
        int   lat;
        cnt_t done_bits;
        cnt_t avail_bits;
        vec_t word;
        e0         = errors;
        lat        = 0;
        done_bits  = '0;
        avail_bits = '0;
        u_mem.clear_valid();
        for (int k = 0; k < N; k++) begin
            for (int i = 0; i < N; i++) begin
                word[i] = tab_a[c][i][k];
            end
            u_mem.load_a(addr_t'(tab_base_a[c] + k * tab_str_a[c]), word);
            for (int j = 0; j < N; j++) begin
                word[j] = tab_b[c][k][j];
            end
            u_mem.load_b(addr_t'(tab_base_b[c] + k * tab_str_b[c]), word);
        end
        @(posedge clk);
        #1;
        log_clear                   = 1'b1;
        address_mat_a               = tab_base_a[c];
        address_mat_b               = tab_base_b[c];
        address_mat_c               = tab_base_c[c];
        address_stride_a            = tab_str_a[c];
        address_stride_b            = tab_str_b[c];
        address_stride_c            = tab_str_c[c];
        validity_mask_a_rows        = tab_mask_rows[c];
        validity_mask_a_cols_b_rows = tab_mask_k[c];
        validity_mask_b_cols        = tab_mask_cols[c];
        @(posedge clk);
        #1;
        log_clear     = 1'b0;
        start_mat_mul = 1'b1;
        do begin
            @(posedge clk);
            @(negedge clk);
            lat++;
        end while (!done_mat_mul && lat < CASE_LIMIT);
        if (!done_mat_mul) begin
            $display("Case %0d: done_mat_mul did not arrive within %0d cycles", c, CASE_LIMIT);
            errors++;
        end else begin
            check_count(cnt_t'(lat), cnt_t'(LATENCY), "done latency");
        end
        // Bit n holds the sample n cycles after done
        done_bits[0]  = done_mat_mul;
        avail_bits[0] = c_data_available;
        for (int n = 1; n < 6; n++) begin
            @(negedge clk);
            done_bits[n]  = done_mat_mul;
            avail_bits[n] = c_data_available;
        end
        check_count(done_bits, 8'h01, "done pulse shape");
        check_count(avail_bits, 8'h1e, "c_data_available window");
        @(posedge clk);
        #1;
        start_mat_mul = 1'b0;
        @(negedge clk);
        check_count(controls(), 8'd0, "control outputs after start drops");
        check_count(cnt_t'(u_mem.a_reads), 8'd4, "A reads");
        check_count(cnt_t'(u_mem.b_reads), 8'd4, "B reads");
        check_count(cnt_t'(u_mem.bad_reads), 8'd0, "reads of unprogrammed addresses");
        check_count(cnt_t'(u_mem.c_writes), 8'd4, "C writes");
        for (int i = 0; i < N; i++) begin
            check_addr(u_mem.c_addr_log[i], addr_t'(tab_base_c[c] + i * tab_str_c[c]),
                       $sformatf("case %0d C row %0d address", c, i));
            check_vec(u_mem.c_data_log[i], golden_row(c, i),
                      $sformatf("case %0d C row %0d data", c, i));
        end
        if (errors != e0) begin
            fails++;
        end
        $display("Case %0d %-26s %s", c, tab_name[c], (errors == e0) ? "passed" : "failed");
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        errors                      = 0;
        fails                       = 0;
        start_mat_mul               = 1'b0;
        log_clear                   = 1'b0;
        address_mat_a               = '0;
        address_mat_b               = '0;
        address_mat_c               = '0;
        address_stride_a            = '0;
        address_stride_b            = '0;
        address_stride_c            = '0;
        validity_mask_a_rows        = '0;
        validity_mask_a_cols_b_rows = '0;
        validity_mask_b_cols        = '0;
        build_table();
        // Sample well inside reset, clear of the first clock transition
        repeat (2) @(negedge clk);
        check_count(controls(), 8'd0, "control outputs during reset");
        @(posedge arst_n);
        @(negedge clk);
        check_count(controls(), 8'd0, "control outputs after reset");
        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);
        end
        $display("Cases run: %0d, cases failed: %0d, checks failed: %0d",
                 NUM_CASES, fails, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (NUM_CASES * CASE_LIMIT + 100) @(posedge clk);
        $display("Watchdog expired, the run did not finish in %0d cycles",
                 NUM_CASES * CASE_LIMIT + 100);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== bench/tb_matmul_mem.sv ====
// Memory model for the multiplier testbench
// A and B answer one cycle after the address, C writes are logged in order

`timescale 1ns/1ps

`include "matmul_params.svh"

module tb_matmul_mem
    import matmul_pkg::*;
(
    input  logic  clk,
    input  logic  log_clear,
    input  logic  a_mem_access,
    input  logic  b_mem_access,
    input  addr_t a_addr,
    input  addr_t b_addr,
    input  logic  c_data_available,
    input  addr_t c_addr,
    input  vec_t  c_data_out,
    output vec_t  a_data,
    output vec_t  b_data
);

    localparam int DEPTH = 1 << `AWIDTH;
    // Returned for any address that was never programmed
    localparam vec_t POISON = {4{16'hdead}};

    vec_t  a_mem [DEPTH];
    vec_t  b_mem [DEPTH];
    bit    a_set [DEPTH];
    bit    b_set [DEPTH];
    vec_t  a_q = POISON;
    vec_t  b_q = POISON;
    int    a_reads;
    int    b_reads;
    int    bad_reads;
    int    c_writes;
    addr_t c_addr_log [4];
    vec_t  c_data_log [4];

    task automatic clear_valid();
        for (int a = 0; a < DEPTH; a++) begin
            a_set[a] = 1'b0;
            b_set[a] = 1'b0;
        end
    endtask

    task automatic load_a(input addr_t addr, input vec_t data);
        a_mem[addr] = data;
        a_set[addr] = 1'b1;
    endtask

    task automatic load_b(input addr_t addr, input vec_t data);
        b_mem[addr] = data;
        b_set[addr] = 1'b1;
    endtask

    always @(posedge clk) begin
        if (a_mem_access) begin
            a_q <= a_set[a_addr] ? a_mem[a_addr] : POISON;
        end
        if (b_mem_access) begin
            b_q <= b_set[b_addr] ? b_mem[b_addr] : POISON;
        end
        if (log_clear) begin
            a_reads   <= 0;
            b_reads   <= 0;
            bad_reads <= 0;
            c_writes  <= 0;
        end else begin
            a_reads   <= a_reads + int'(a_mem_access);
            b_reads   <= b_reads + int'(b_mem_access);
            bad_reads <= bad_reads + int'(a_mem_access && !a_set[a_addr])
                                   + int'(b_mem_access && !b_set[b_addr]);
            if (c_data_available) begin
                c_addr_log[c_writes[1:0]] <= c_addr;
                c_data_log[c_writes[1:0]] <= c_data_out;
                c_writes <= c_writes + 1;
            end
        end
    end

    assign a_data = a_q;
    assign b_data = b_q;

endmodule

// ==== bench/tb_clock_gen.sv ====
// Testbench clock and reset
// 10 ns clock, active-low reset held for three rising edges

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
    end

    always #5 clk = ~clk;

endmodule

// ==== logic/matmul_4x4_systolic.sv ====
// 4x4 systolic matrix multiplier
// Fetches A and B, runs them through a PE grid and writes C back row by row

`timescale 1ns/1ps

`include "matmul_params.svh"

module matmul_4x4_systolic
    import matmul_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    start_mat_mul,
    output logic    done_mat_mul,
    input  addr_t   address_mat_a,
    input  addr_t   address_mat_b,
    input  addr_t   address_mat_c,
    input  stride_t address_stride_a,
    input  stride_t address_stride_b,
    input  stride_t address_stride_c,
    input  mask_t   validity_mask_a_rows,
    input  mask_t   validity_mask_a_cols_b_rows,
    input  mask_t   validity_mask_b_cols,
    input  vec_t    a_data,
    input  vec_t    b_data,
    output addr_t   a_addr,
    output addr_t   b_addr,
    output addr_t   c_addr,
    output logic    a_mem_access,
    output logic    b_mem_access,
    output logic    c_data_available,
    output vec_t    c_data_out
);

    // Array drain time plus the MAC pipeline depth
    localparam cnt_t DONE_CNT = cnt_t'(`CYCLES_FOR_MATMUL + `NUM_CYCLES_IN_MAC);

    cnt_t                     clk_cnt;
    vec_t                     a_skewed;
    vec_t                     b_skewed;
    vec_t [`MAT_MUL_SIZE-1:0] result;

    ////////////////////////////////////////
    // Cycle counter and done
    ////////////////////////////////////////

    // Counts from the first cycle of start and parks at its top value
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_cnt <= '0;
        end else if (!start_mat_mul) begin
            clk_cnt <= '0;
        end else if (clk_cnt != '1) begin
            clk_cnt <= clk_cnt + 8'd1;
        end
    end

    assign done_mat_mul = start_mat_mul && (clk_cnt == DONE_CNT);

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////

    systolic_data_setup u_systolic_data_setup (
        .clk                         (clk),
        .arst_n                      (arst_n),
        .start_mat_mul               (start_mat_mul),
        .clk_cnt                     (clk_cnt),
        .address_mat_a               (address_mat_a),
        .address_mat_b               (address_mat_b),
        .address_stride_a            (address_stride_a),
        .address_stride_b            (address_stride_b),
        .validity_mask_a_rows        (validity_mask_a_rows),
        .validity_mask_a_cols_b_rows (validity_mask_a_cols_b_rows),
        .validity_mask_b_cols        (validity_mask_b_cols),
        .a_data                      (a_data),
        .b_data                      (b_data),
        .a_addr                      (a_addr),
        .b_addr                      (b_addr),
        .a_mem_access                (a_mem_access),
        .b_mem_access                (b_mem_access),
        .a_skewed                    (a_skewed),
        .b_skewed                    (b_skewed)
    );

    systolic_pe_matrix u_systolic_pe_matrix (
        .clk           (clk),
        .arst_n        (arst_n),
        .start_mat_mul (start_mat_mul),
        .a_edge        (a_skewed),
        .b_edge        (b_skewed),
        .result        (result)
    );

    output_logic u_output_logic (
        .clk                  (clk),
        .arst_n               (arst_n),
        .done_mat_mul         (done_mat_mul),
        .address_mat_c        (address_mat_c),
        .address_stride_c     (address_stride_c),
        .validity_mask_a_rows (validity_mask_a_rows),
        .validity_mask_b_cols (validity_mask_b_cols),
        .result               (result),
        .c_addr               (c_addr),
        .c_data_out           (c_data_out),
        .c_data_available     (c_data_available)
    );

endmodule

// ==== logic/output_logic.sv ====
// Result drain
// Latches the masked C matrix at done and writes it to C memory one row per cycle

`timescale 1ns/1ps

`include "matmul_params.svh"

module output_logic
    import matmul_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     done_mat_mul,
    input  addr_t                    address_mat_c,
    input  stride_t                  address_stride_c,
    input  mask_t                    validity_mask_a_rows,
    input  mask_t                    validity_mask_b_cols,
    input  vec_t [`MAT_MUL_SIZE-1:0] result,
    output addr_t                    c_addr,
    output vec_t                     c_data_out,
    output logic                     c_data_available
);

    localparam int ROW_W = $clog2(`MAT_MUL_SIZE);

    vec_t [`MAT_MUL_SIZE-1:0] c_masked;
    vec_t [`MAT_MUL_SIZE-1:0] c_buf;
    logic [ROW_W-1:0]         row_idx;
    logic                     draining;

    // C(i,j) survives only if row i of A and column j of B are both valid
    always_comb begin
        for (int i = 0; i < `MAT_MUL_SIZE; i++) begin
            for (int j = 0; j < `MAT_MUL_SIZE; j++) begin
                if (validity_mask_a_rows[i] && validity_mask_b_cols[j]) begin
                    c_masked[i][j] = result[i][j];
                end else begin
                    c_masked[i][j] = '0;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Row sequencer
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            draining <= 1'b0;
            row_idx  <= '0;
        end else if (done_mat_mul) begin
            draining <= 1'b1;
            row_idx  <= '0;
        end else if (draining) begin
            if (row_idx == ROW_W'(`MAT_MUL_SIZE - 1)) begin
                draining <= 1'b0;
            end
            row_idx <= row_idx + 1'b1;
        end
    end

    // Snapshot taken once, the array may be cleared while rows go out
    always_ff @(posedge clk) begin
        if (done_mat_mul) begin
            c_buf <= c_masked;
        end
    end

    assign c_data_available = draining;
    assign c_data_out       = c_buf[row_idx];
    assign c_addr = address_mat_c + addr_t'(row_idx) * addr_t'(address_stride_c);

endmodule

// ==== logic/systolic_data_setup.sv ====
// Systolic operand setup
// Fetches A columns and B rows, masks them and skews them onto the array edges

`timescale 1ns/1ps

`include "matmul_params.svh"

module systolic_data_setup
    import matmul_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    start_mat_mul,
    input  cnt_t    clk_cnt,
    input  addr_t   address_mat_a,
    input  addr_t   address_mat_b,
    input  stride_t address_stride_a,
    input  stride_t address_stride_b,
    input  mask_t   validity_mask_a_rows,
    input  mask_t   validity_mask_a_cols_b_rows,
    input  mask_t   validity_mask_b_cols,
    input  vec_t    a_data,
    input  vec_t    b_data,
    output addr_t   a_addr,
    output addr_t   b_addr,
    output logic    a_mem_access,
    output logic    b_mem_access,
    output vec_t    a_skewed,
    output vec_t    b_skewed
);

    localparam int IDX_W = $clog2(`MAT_MUL_SIZE);

    logic             fetch_active;
    logic [IDX_W-1:0] fetch_k;
    logic             fetch_vld;
    logic [IDX_W-1:0] fetch_idx;
    logic             k_ok;
    vec_t             a_masked;
    vec_t             b_masked;

    ////////////////////////////////////////
    // Address generation
    ////////////////////////////////////////

    // One vector per count, A column k and B row k
    assign fetch_active = start_mat_mul && (clk_cnt < cnt_t'(`MAT_MUL_SIZE));
    assign fetch_k      = clk_cnt[IDX_W-1:0];

    assign a_mem_access = fetch_active;
    assign b_mem_access = fetch_active;
    assign a_addr = address_mat_a + addr_t'(fetch_k) * addr_t'(address_stride_a);
    assign b_addr = address_mat_b + addr_t'(fetch_k) * addr_t'(address_stride_b);

    // The memories answer one cycle later, so remember which k is on the bus
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_vld <= 1'b0;
            fetch_idx <= '0;
        end else begin
            fetch_vld <= fetch_active;
            fetch_idx <= fetch_k;
        end
    end

    ////////////////////////////////////////
    // Input masking
    ////////////////////////////////////////

    // Outside the fetch window the edges see zeros, so idle cycles add nothing
    assign k_ok = fetch_vld && validity_mask_a_cols_b_rows[fetch_idx];

    always_comb begin
        for (int i = 0; i < `MAT_MUL_SIZE; i++) begin
            a_masked[i] = (k_ok && validity_mask_a_rows[i]) ? a_data[i] : '0;
            b_masked[i] = (k_ok && validity_mask_b_cols[i]) ? b_data[i] : '0;
        end
    end

    ////////////////////////////////////////
    // Staircase skew
    ////////////////////////////////////////

    // Row i of A and column i of B are held back by i cycles
    for (genvar i = 0; i < `MAT_MUL_SIZE; i++) begin : g_skew
        if (i == 0) begin : g_edge
            assign a_skewed[i] = a_masked[i];
            assign b_skewed[i] = b_masked[i];
        end else begin : g_stair
            elem_t [i-1:0] a_pipe;
            elem_t [i-1:0] b_pipe;

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    a_pipe <= '0;
                    b_pipe <= '0;
                end else if (!start_mat_mul) begin
                    a_pipe <= '0;
                    b_pipe <= '0;
                end else begin
                    a_pipe[0] <= a_masked[i];
                    b_pipe[0] <= b_masked[i];
                    for (int d = 1; d < i; d++) begin
                        a_pipe[d] <= a_pipe[d-1];
                        b_pipe[d] <= b_pipe[d-1];
                    end
                end
            end

            assign a_skewed[i] = a_pipe[i-1];
            assign b_skewed[i] = b_pipe[i-1];
        end
    end

endmodule

// ==== logic/systolic_pe_matrix.sv ====
// Systolic PE grid
// A values travel right and B values travel down through a 4x4 array of MAC cells

`timescale 1ns/1ps

`include "matmul_params.svh"

module systolic_pe_matrix
    import matmul_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       start_mat_mul,
    input  vec_t                       a_edge,
    input  vec_t                       b_edge,
    output vec_t [`MAT_MUL_SIZE-1:0]   result
);

    logic clear;

    // a_link[i][j] feeds PE(i,j) from the west
    // b_link[i][j] feeds PE(i,j) from the north
    elem_t a_link [`MAT_MUL_SIZE][`MAT_MUL_SIZE+1];
    elem_t b_link [`MAT_MUL_SIZE+1][`MAT_MUL_SIZE];

    // Accumulators hold their sums only while a run is in progress
    assign clear = !start_mat_mul;

    ////////////////////////////////////////
    // Array edges
    ////////////////////////////////////////

    for (genvar k = 0; k < `MAT_MUL_SIZE; k++) begin : g_edges
        assign a_link[k][0] = a_edge[k];
        assign b_link[0][k] = b_edge[k];
    end

    ////////////////////////////////////////
    // PE grid
    ////////////////////////////////////////

    for (genvar i = 0; i < `MAT_MUL_SIZE; i++) begin : g_row
        for (genvar j = 0; j < `MAT_MUL_SIZE; j++) begin : g_col
            systolic_pe u_pe (
                .clk    (clk),
                .arst_n (arst_n),
                .clear  (clear),
                .a_in   (a_link[i][j]),
                .b_in   (b_link[i][j]),
                .a_out  (a_link[i][j+1]),
                .b_out  (b_link[i+1][j]),
                .acc    (result[i][j])
            );
        end
    end

endmodule

// ==== logic/systolic_pe.sv ====
// Systolic processing element
// Multiply-accumulate cell that also forwards its operands right and down

`timescale 1ns/1ps

module systolic_pe
    import matmul_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  clear,
    input  elem_t a_in,
    input  elem_t b_in,
    output elem_t a_out,
    output elem_t b_out,
    output elem_t acc
);

    elem_t product;

    // Only the low half of the product is kept, so the sum wraps mod 2^16
    assign product = a_in * b_in;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else if (clear) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else begin
            a_out <= a_in;
            b_out <= b_in;
            acc   <= acc + product;
        end
    end

endmodule

// ==== logic/matmul_pkg.sv ====
// Matrix multiplier types
// Element, memory word, address, stride, mask and cycle count types

`include "matmul_params.svh"

package matmul_pkg;

    typedef logic signed [`DWIDTH-1:0] elem_t;

    // One memory word, element 0 sits in the low bits
    typedef elem_t [`MAT_MUL_SIZE-1:0] vec_t;

    typedef logic [`AWIDTH-1:0]            addr_t;
    typedef logic [`ADDR_STRIDE_WIDTH-1:0] stride_t;
    typedef logic [`MASK_WIDTH-1:0]        mask_t;
    typedef logic [7:0]                    cnt_t;

endpackage

// ==== logic/matmul_params.svh ====
// Matrix multiplier sizing
// Widths, array dimension and cycle counts shared by the package and RTL

`ifndef MATMUL_PARAMS_SVH
`define MATMUL_PARAMS_SVH

`define DWIDTH             16
`define AWIDTH             10
`define ADDR_STRIDE_WIDTH  8
`define MAT_MUL_SIZE       4
`define MASK_WIDTH         4

// Pipeline depth of one PE and the drain time of the array
`define NUM_CYCLES_IN_MAC  1
`define CYCLES_FOR_MATMUL  14

`endif
